// File: tb.f
logic/rv_pkg.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_bru.sv
logic/rv_ifu_stage.sv
logic/rv_id_stage.sv
logic/rv_ex_stage.sv
logic/rv_cpu.sv
verification/rv_cpu_props.sv
verification/tb_rv_cpu.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_cpu \
	-f tb.f --Mdir obj_dir -o sim_tb

# the log decides pass or fail, so a nonzero exit from the model is not fatal here
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
	exit 0
fi
exit 1

// File: verification/tb_rv_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_cpu;

	localparam rv_pkg::xlen_t RESET_PC  = 32'h0000_1000;
	localparam int            N_RANDOM   = 64;
	localparam int            N_RETIRE   = 100;
	localparam int            MAX_CYCLES = N_RETIRE * 12;
	localparam logic [31:0]   LFSR_SEED  = 32'h51c7c9eb;
	localparam logic [31:0]   LFSR_TAPS  = 32'h80200003;

	typedef struct packed {
		rv_pkg::xlen_t    pc;
		logic             wen;
		rv_pkg::reg_idx_t rd;
		rv_pkg::xlen_t    value;
	} expect_t;

	logic             clock;
	logic             arst_n_i;
	rv_pkg::xlen_t    inst_paddr_o;
	logic             inst_psel_o;
	logic             inst_penable_o;
	rv_pkg::inst_t    inst_prdata_i;
	logic             inst_pready_i;
	logic             retire_valid_o;
	rv_pkg::xlen_t    retire_pc_o;
	logic             retire_wen_o;
	rv_pkg::reg_idx_t retire_rd_o;
	rv_pkg::xlen_t    retire_wdata_o;

	rv_pkg::inst_t imem [0:127];
	rv_pkg::xlen_t model_regs [0:31];
	rv_pkg::xlen_t model_pc;
	logic [31:0]   lfsr_q;
	int            cycle_count;
	int            retire_count;
	int            error_count;
	int            ready_cycle;
	logic          ready_seen;
	logic          setup_seen;
	expect_t       exp_q;

	rv_cpu #(
		.RESET_PC (RESET_PC)
	) dut (
		.clock          (clock),
		.arst_n_i       (arst_n_i),
		.inst_paddr_o   (inst_paddr_o),
		.inst_psel_o    (inst_psel_o),
		.inst_penable_o (inst_penable_o),
		.inst_prdata_i  (inst_prdata_i),
		.inst_pready_i  (inst_pready_i),
		.retire_valid_o (retire_valid_o),
		.retire_pc_o    (retire_pc_o),
		.retire_wen_o   (retire_wen_o),
		.retire_rd_o    (retire_rd_o),
		.retire_wdata_o (retire_wdata_o)
	);

	initial begin
		clock = 1'b0;
	end

	always #2 clock = ~clock;

	function automatic logic lfsr_bit();
		logic b;
		b = lfsr_q[0];
		lfsr_q = lfsr_q >> 1;
		if (b) begin
			lfsr_q = lfsr_q ^ LFSR_TAPS;
		end
		return b;
	endfunction

	function automatic logic [31:0] rand_field(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_bit()};
		end
		return v;
	endfunction

	// instruction encoders
	function automatic rv_pkg::inst_t enc_r(input logic [6:0] f7, input rv_pkg::reg_idx_t rs2,
		input rv_pkg::reg_idx_t rs1, input logic [2:0] f3, input rv_pkg::reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic rv_pkg::inst_t enc_i(input logic [11:0] imm, input rv_pkg::reg_idx_t rs1,
		input logic [2:0] f3, input rv_pkg::reg_idx_t rd);
		return {imm, rs1, f3, rd, 7'b0010011};
	endfunction

	function automatic rv_pkg::inst_t enc_u(input logic [19:0] imm, input rv_pkg::reg_idx_t rd);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic rv_pkg::inst_t enc_b(input logic [12:0] off, input rv_pkg::reg_idx_t rs2,
		input rv_pkg::reg_idx_t rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic rv_pkg::inst_t enc_j(input logic [20:0] off, input rv_pkg::reg_idx_t rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	task automatic build_program();
		logic [2:0]       kind;
		logic [2:0]       sel;
		logic [2:0]       f3;
		logic             sub_bit;
		rv_pkg::reg_idx_t rd;
		rv_pkg::reg_idx_t rs1;
		rv_pkg::reg_idx_t rs2;
		// custom-0 opcode carrying the word index, never reached by a correct core
		for (int i = 0; i < 128; i++) begin
			imem[i] = {i[24:0], 7'b0001011};
		end
		for (int i = 0; i < N_RANDOM; i++) begin
			kind = 3'(rand_field(3));
			sel = 3'(rand_field(3));
			sub_bit = 1'(rand_field(1));
			// small register window, so results feed each other and x0 gets hit
			rd = 5'(rand_field(3));
			rs1 = 5'(rand_field(3));
			rs2 = 5'(rand_field(3));
			case (sel)
				3'd1, 3'd6: f3 = 3'b010;
				3'd2: f3 = 3'b100;
				3'd3: f3 = 3'b110;
				3'd4, 3'd7: f3 = 3'b111;
				default: f3 = 3'b000;
			endcase
			case (kind)
				3'd0: imem[i] = enc_u(20'(rand_field(20)), rd);
				3'd1, 3'd2, 3'd3: imem[i] = enc_i(12'(rand_field(12)), rs1, f3, rd);
				default: imem[i] = enc_r((sub_bit && f3 == 3'b000) ? 7'h20 : 7'h00,
					rs2, rs1, f3, rd);
			endcase
		end
		// fixed corner cases and branch block
		imem[64] = enc_i(12'hfff, 5'd0, 3'b000, 5'd1);
		imem[65] = enc_r(7'h00, 5'd0, 5'd1, 3'b010, 5'd2);
		imem[66] = enc_r(7'h20, 5'd2, 5'd0, 3'b000, 5'd3);
		imem[67] = enc_i(12'd5, 5'd1, 3'b000, 5'd0);
		imem[68] = enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd4);
		imem[69] = enc_b(13'd8, 5'd2, 5'd2, 3'b000);
		imem[70] = enc_i(12'd1, 5'd0, 3'b000, 5'd5);
		imem[71] = enc_b(13'd8, 5'd0, 5'd1, 3'b000);
		imem[72] = enc_b(13'd8, 5'd0, 5'd1, 3'b001);
		imem[73] = enc_i(12'd2, 5'd0, 3'b000, 5'd5);
		imem[74] = enc_j(21'd12, 5'd6);
		imem[77] = 32'h0000_030b;
		// mul, outside rv32i
		imem[78] = enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd7);
		imem[79] = enc_i(12'd7, 5'd0, 3'b000, 5'd7);
		imem[80] = enc_j(21'd0, 5'd0);
	endtask

	// one ISA step of the model machine
	function automatic expect_t model_step(input rv_pkg::inst_t inst);
		expect_t       r;
		logic [6:0]    opc;
		logic [2:0]    f3;
		logic [6:0]    f7;
		rv_pkg::xlen_t a;
		rv_pkg::xlen_t b;
		rv_pkg::xlen_t next_pc;
		logic          wr;
		opc = inst[6:0];
		f3 = inst[14:12];
		f7 = inst[31:25];
		a = model_regs[inst[19:15]];
		b = model_regs[inst[24:20]];
		next_pc = model_pc + 32'd4;
		wr = 1'b0;
		r = '0;
		r.pc = model_pc;
		r.rd = inst[11:7];
		case (opc)
			7'b0110111: begin
				wr = 1'b1;
				r.value = {inst[31:12], 12'h000};
			end
			7'b0010011, 7'b0110011: begin
				if (opc == 7'b0010011) begin
					b = {{20{inst[31]}}, inst[31:20]};
				end
				wr = (opc == 7'b0010011) || (f7 == 7'h00) || (f7 == 7'h20 && f3 == 3'b000);
				case (f3)
					3'b000: r.value = (opc == 7'b0110011 && f7 == 7'h20) ? a - b : a + b;
					3'b010: r.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					3'b100: r.value = a ^ b;
					3'b110: r.value = a | b;
					3'b111: r.value = a & b;
					default: wr = 1'b0;
				endcase
			end
			7'b1100011: begin
				if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
					next_pc = model_pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
						inst[11:8], 1'b0};
				end
			end
			7'b1101111: begin
				wr = 1'b1;
				r.value = model_pc + 32'd4;
				next_pc = model_pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
					inst[30:21], 1'b0};
			end
			default: ;
		endcase
		r.wen = wr && (r.rd != 5'd0);
		if (r.wen) begin
			model_regs[r.rd] = r.value;
		end
		model_pc = next_pc;
		return r;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
		error_count++;
	endtask

	task automatic end_run();
		$display("retired %0d of %0d instructions, %0d errors", retire_count, N_RETIRE,
			error_count);
		if (error_count == 0 && retire_count == N_RETIRE) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	endtask

	initial begin
		lfsr_q = LFSR_SEED;
		cycle_count = 0;
		retire_count = 0;
		error_count = 0;
		ready_cycle = 0;
		ready_seen = 1'b0;
		setup_seen = 1'b0;
		arst_n_i = 1'b0;
		inst_pready_i = 1'b0;
		inst_prdata_i = '0;
		build_program();
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		model_pc = RESET_PC;
		repeat (3) @(posedge clock);
		arst_n_i <= 1'b1;
	end

	// apb slave with random wait states
	always @(posedge clock) begin
		inst_pready_i <= lfsr_bit();
		inst_prdata_i <= imem[inst_paddr_o[8:2]];
	end

	always @(posedge clock) begin
		if (arst_n_i) begin
			cycle_count = cycle_count + 1;
			if (cycle_count >= MAX_CYCLES) begin
				$display("timeout after %0d cycles, only %0d of %0d instructions retired",
					cycle_count, retire_count, N_RETIRE);
				error_count++;
				end_run();
			end
		end
	end

	always @(negedge clock) begin
		if (arst_n_i) begin
			if (inst_psel_o && !inst_penable_o && !setup_seen) begin
				setup_seen = 1'b1;
				if (inst_paddr_o != RESET_PC) begin
					report_mismatch("inst_paddr_o", RESET_PC, inst_paddr_o);
				end
			end
			if (retire_valid_o) begin
				if (!setup_seen) begin
					$display("retire seen before the first fetch setup phase");
					error_count++;
				end
				if (!ready_seen || cycle_count != ready_cycle + 2) begin
					$display("retire at cycle %0d is not 2 cycles after pready (cycle %0d)",
						cycle_count, ready_cycle);
					error_count++;
				end
				ready_seen = 1'b0;
				exp_q = model_step(imem[model_pc[8:2]]);
				if (retire_pc_o != exp_q.pc) begin
					report_mismatch("retire_pc_o", exp_q.pc, retire_pc_o);
				end
				if (retire_wen_o != exp_q.wen) begin
					report_mismatch("retire_wen_o", 32'(exp_q.wen), 32'(retire_wen_o));
				end
				if (exp_q.wen && retire_rd_o != exp_q.rd) begin
					report_mismatch("retire_rd_o", 32'(exp_q.rd), 32'(retire_rd_o));
				end
				if (exp_q.wen && retire_wdata_o != exp_q.value) begin
					report_mismatch("retire_wdata_o", exp_q.value, retire_wdata_o);
				end
				retire_count++;
			end
			if (inst_psel_o && inst_penable_o && inst_pready_i) begin
				ready_cycle = cycle_count;
				ready_seen = 1'b1;
			end
			if (retire_count == N_RETIRE) begin
				end_run();
			end
		end
	end

endmodule

`default_nettype wire

// File: verification/rv_cpu_props.sv
`timescale 1ns/1ps
`default_nettype none

module rv_cpu_props (
	input wire                clock,
	input wire                arst_n_i,
	input wire rv_pkg::xlen_t inst_paddr_o,
	input wire                inst_psel_o,
	input wire                inst_penable_o,
	input wire                inst_pready_i,
	input wire                retire_valid_o
);

	// setup and waiting access cycles keep the transfer open
	apb_hold: assert property (@(posedge clock) disable iff (!arst_n_i)
		(inst_psel_o && !(inst_penable_o && inst_pready_i)) |=>
		(inst_psel_o && $stable(inst_paddr_o)))
		else $error("apb paddr or psel changed before pready");

	// an access cycle always follows a cycle with psel already high
	apb_enable: assert property (@(posedge clock) disable iff (!arst_n_i)
		inst_penable_o |-> (inst_psel_o && $past(inst_psel_o)))
		else $error("apb penable high without a preceding psel cycle");

	retire_pulse: assert property (@(posedge clock) disable iff (!arst_n_i)
		retire_valid_o |=> !retire_valid_o)
		else $error("retire valid high for two cycles");

	// checked mid-cycle, after the first reset edge has settled the fsm
	reset_idle: assert property (@(negedge clock)
		!arst_n_i |-> !inst_psel_o)
		else $error("apb psel high during reset");

endmodule

bind rv_cpu rv_cpu_props u_props (
	.clock          (clock),
	.arst_n_i       (arst_n_i),
	.inst_paddr_o   (inst_paddr_o),
	.inst_psel_o    (inst_psel_o),
	.inst_penable_o (inst_penable_o),
	.inst_pready_i  (inst_pready_i),
	.retire_valid_o (retire_valid_o)
);

`default_nettype wire

// File: logic/rv_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_cpu #(
	parameter rv_pkg::xlen_t RESET_PC = '0
) (
	input  wire                    clock,
	input  wire                    arst_n_i,

	// apb instruction port
	output rv_pkg::xlen_t          inst_paddr_o,
	output logic                   inst_psel_o,
	output logic                   inst_penable_o,
	input  wire rv_pkg::inst_t     inst_prdata_i,
	input  wire                    inst_pready_i,

	// retire trace
	output logic                   retire_valid_o,
	output rv_pkg::xlen_t          retire_pc_o,
	output logic                   retire_wen_o,
	output rv_pkg::reg_idx_t       retire_rd_o,
	output rv_pkg::xlen_t          retire_wdata_o
);

	logic                  fs_to_ds_valid;
	rv_pkg::fs_to_ds_bus_t fs_to_ds_bus;
	logic                  ds_allowin;
	logic                  es_valid;
	rv_pkg::ds_to_es_bus_t ds_to_es_bus;
	rv_pkg::redirect_t     redirect;
	rv_pkg::reg_idx_t      rs1;
	rv_pkg::reg_idx_t      rs2;
	rv_pkg::xlen_t         rdata1;
	rv_pkg::xlen_t         rdata2;
	logic                  reg_wen;
	rv_pkg::reg_idx_t      reg_waddr;
	rv_pkg::xlen_t         reg_wdata;

	rv_ifu_stage #(
		.RESET_PC (RESET_PC)
	) u_ifu_stage (
		.clock            (clock),
		.arst_n_i         (arst_n_i),
		.redirect_i       (redirect),
		.ds_allowin_i     (ds_allowin),
		.fs_to_ds_valid_o (fs_to_ds_valid),
		.fs_to_ds_bus_o   (fs_to_ds_bus),
		.paddr_o          (inst_paddr_o),
		.psel_o           (inst_psel_o),
		.penable_o        (inst_penable_o),
		.prdata_i         (inst_prdata_i),
		.pready_i         (inst_pready_i)
	);

	rv_id_stage u_id_stage (
		.clock            (clock),
		.arst_n_i         (arst_n_i),
		.fs_to_ds_valid_i (fs_to_ds_valid),
		.fs_to_ds_bus_i   (fs_to_ds_bus),
		.ds_allowin_o     (ds_allowin),
		.rs1_o            (rs1),
		.rs2_o            (rs2),
		.rdata1_i         (rdata1),
		.rdata2_i         (rdata2),
		.retire_i         (retire_valid_o),
		.es_valid_o       (es_valid),
		.ds_to_es_bus_o   (ds_to_es_bus)
	);

	rv_regfile u_regfile (
		.clock    (clock),
		.arst_n_i (arst_n_i),
		.raddr1_i (rs1),
		.raddr2_i (rs2),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2),
		.wen_i    (reg_wen),
		.waddr_i  (reg_waddr),
		.wdata_i  (reg_wdata)
	);

	rv_ex_stage u_ex_stage (
		.es_valid_i     (es_valid),
		.ds_to_es_bus_i (ds_to_es_bus),
		.reg_wen_o      (reg_wen),
		.reg_waddr_o    (reg_waddr),
		.reg_wdata_o    (reg_wdata),
		.redirect_o     (redirect),
		.retire_valid_o (retire_valid_o),
		.retire_pc_o    (retire_pc_o),
		.retire_wen_o   (retire_wen_o),
		.retire_rd_o    (retire_rd_o),
		.retire_wdata_o (retire_wdata_o)
	);

endmodule

`default_nettype wire

// File: logic/rv_ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rv_ex_stage (
	input  wire                         es_valid_i,
	input  wire rv_pkg::ds_to_es_bus_t  ds_to_es_bus_i,
	output logic                        reg_wen_o,
	output rv_pkg::reg_idx_t            reg_waddr_o,
	output rv_pkg::xlen_t               reg_wdata_o,
	output rv_pkg::redirect_t           redirect_o,
	output logic                        retire_valid_o,
	output rv_pkg::xlen_t               retire_pc_o,
	output logic                        retire_wen_o,
	output rv_pkg::reg_idx_t            retire_rd_o,
	output rv_pkg::xlen_t               retire_wdata_o
);

	rv_pkg::xlen_t alu_b;
	rv_pkg::xlen_t alu_result;
	logic          taken;
	rv_pkg::xlen_t target;
	rv_pkg::xlen_t link;
	logic          is_branch;
	logic          wen;
	rv_pkg::xlen_t wdata;

	assign alu_b = ds_to_es_bus_i.use_imm ? ds_to_es_bus_i.imm : ds_to_es_bus_i.src2;

	rv_alu u_alu (
		.op_i     (ds_to_es_bus_i.alu_op),
		.a_i      (ds_to_es_bus_i.src1),
		.b_i      (alu_b),
		.result_o (alu_result)
	);

	rv_bru u_bru (
		.op_i     (ds_to_es_bus_i.bru_op),
		.pc_i     (ds_to_es_bus_i.pc),
		.src1_i   (ds_to_es_bus_i.src1),
		.src2_i   (ds_to_es_bus_i.src2),
		.imm_i    (ds_to_es_bus_i.imm),
		.taken_o  (taken),
		.target_o (target),
		.link_o   (link)
	);

	assign is_branch = (ds_to_es_bus_i.bru_op == rv_pkg::BRU_BEQ) ||
		(ds_to_es_bus_i.bru_op == rv_pkg::BRU_BNE);

	// no write for conditional branches or rd x0
	assign wen   = es_valid_i && ds_to_es_bus_i.wen && !is_branch &&
		(ds_to_es_bus_i.rd != '0);
	assign wdata = (ds_to_es_bus_i.bru_op == rv_pkg::BRU_JAL) ? link : alu_result;

	assign reg_wen_o   = wen;
	assign reg_waddr_o = ds_to_es_bus_i.rd;
	assign reg_wdata_o = wdata;

	// fetch has no predictor, so every executed instruction sends its next pc
	assign redirect_o.valid = es_valid_i;
	assign redirect_o.pc    = taken ? target : link;

	assign retire_valid_o = es_valid_i;
	assign retire_pc_o    = ds_to_es_bus_i.pc;
	assign retire_wen_o   = wen;
	assign retire_rd_o    = ds_to_es_bus_i.rd;
	assign retire_wdata_o = wdata;

endmodule

`default_nettype wire

// File: logic/rv_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rv_id_stage (
	input  wire                         clock,
	input  wire                         arst_n_i,
	input  wire                         fs_to_ds_valid_i,
	input  wire rv_pkg::fs_to_ds_bus_t  fs_to_ds_bus_i,
	output logic                        ds_allowin_o,
	output rv_pkg::reg_idx_t            rs1_o,
	output rv_pkg::reg_idx_t            rs2_o,
	input  wire rv_pkg::xlen_t          rdata1_i,
	input  wire rv_pkg::xlen_t          rdata2_i,
	input  wire                         retire_i,
	output logic                        es_valid_o,
	output rv_pkg::ds_to_es_bus_t       ds_to_es_bus_o
);

	rv_pkg::inst_t         inst;
	logic [6:0]            opcode;
	logic [2:0]            funct3;
	logic [6:0]            funct7;
	rv_pkg::xlen_t         imm_i;
	rv_pkg::xlen_t         imm_u;
	rv_pkg::xlen_t         imm_b;
	rv_pkg::xlen_t         imm_j;
	logic                  legal_f7;
	logic                  ds_go;
	logic                  es_valid_q;
	rv_pkg::ds_to_es_bus_t dec_bus;
	rv_pkg::ds_to_es_bus_t bus_q;

	assign inst   = fs_to_ds_bus_i.inst;
	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	// register form allows funct7 0, or 0x20 for sub only
	assign legal_f7 = (opcode == rv_pkg::OPC_OP_IMM) || (funct7 == 7'h00) ||
		(funct7 == 7'h20 && funct3 == 3'b000);

	assign rs1_o = inst[19:15];
	assign rs2_o = inst[24:20];

	always_comb begin
		dec_bus         = '0;
		dec_bus.pc      = fs_to_ds_bus_i.pc;
		dec_bus.src1    = rdata1_i;
		dec_bus.src2    = rdata2_i;
		dec_bus.imm     = imm_i;
		dec_bus.alu_op  = rv_pkg::ALU_ADD;
		dec_bus.bru_op  = rv_pkg::BRU_NONE;
		dec_bus.rd      = inst[11:7];
		case (opcode)
			rv_pkg::OPC_LUI: begin
				dec_bus.imm     = imm_u;
				dec_bus.use_imm = 1'b1;
				dec_bus.alu_op  = rv_pkg::ALU_PASS_B;
				dec_bus.wen     = 1'b1;
			end
			rv_pkg::OPC_OP_IMM, rv_pkg::OPC_OP: begin
				dec_bus.use_imm = (opcode == rv_pkg::OPC_OP_IMM);
				dec_bus.wen     = legal_f7;
				case (funct3)
					3'b000: dec_bus.alu_op = funct7[5] && !dec_bus.use_imm ?
						rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
					3'b010: dec_bus.alu_op = rv_pkg::ALU_SLT;
					3'b100: dec_bus.alu_op = rv_pkg::ALU_XOR;
					3'b110: dec_bus.alu_op = rv_pkg::ALU_OR;
					3'b111: dec_bus.alu_op = rv_pkg::ALU_AND;
					default: dec_bus.wen = 1'b0;
				endcase
			end
			rv_pkg::OPC_BRANCH: begin
				dec_bus.imm = imm_b;
				if (funct3 == 3'b000) begin
					dec_bus.bru_op = rv_pkg::BRU_BEQ;
				end else if (funct3 == 3'b001) begin
					dec_bus.bru_op = rv_pkg::BRU_BNE;
				end
			end
			rv_pkg::OPC_JAL: begin
				dec_bus.imm    = imm_j;
				dec_bus.bru_op = rv_pkg::BRU_JAL;
				dec_bus.wen    = 1'b1;
			end
			// anything else falls through as a no-op
			default: ;
		endcase
	end

	// one instruction in flight, so decode is free whenever execute is empty
	assign ds_allowin_o = !es_valid_q;
	assign ds_go        = fs_to_ds_valid_i && ds_allowin_o;

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			es_valid_q <= 1'b0;
		end else if (ds_go) begin
			es_valid_q <= 1'b1;
		end else if (retire_i) begin
			es_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (ds_go) begin
			bus_q <= dec_bus;
		end
	end

	assign es_valid_o     = es_valid_q;
	assign ds_to_es_bus_o = bus_q;

endmodule

`default_nettype wire

// File: logic/rv_ifu_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rv_ifu_stage #(
	parameter rv_pkg::xlen_t RESET_PC = '0
) (
	input  wire                        clock,
	input  wire                        arst_n_i,
	input  wire rv_pkg::redirect_t     redirect_i,
	input  wire                        ds_allowin_i,
	output logic                       fs_to_ds_valid_o,
	output rv_pkg::fs_to_ds_bus_t      fs_to_ds_bus_o,
	output rv_pkg::xlen_t              paddr_o,
	output logic                       psel_o,
	output logic                       penable_o,
	input  wire rv_pkg::inst_t         prdata_i,
	input  wire                        pready_i
);

	typedef enum logic [1:0] {
		IDLE,
		SETUP,
		ACCESS,
		WAIT_EXEC
	} state_e;

	state_e        state_q;
	rv_pkg::xlen_t pc_q;
	rv_pkg::inst_t inst_q;
	logic          fs_valid_q;

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q    <= IDLE;
			pc_q       <= RESET_PC;
			fs_valid_q <= 1'b0;
		end else begin
			// word leaves for decode once decode accepts it
			if (fs_valid_q && ds_allowin_i) begin
				fs_valid_q <= 1'b0;
			end
			case (state_q)
				IDLE: state_q <= SETUP;
				SETUP: state_q <= ACCESS;
				ACCESS: begin
					if (pready_i) begin
						fs_valid_q <= 1'b1;
						state_q    <= WAIT_EXEC;
					end
				end
				WAIT_EXEC: begin
					// execute always reports the next pc, taken or not
					if (redirect_i.valid) begin
						pc_q    <= redirect_i.pc;
						state_q <= SETUP;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// instruction word, sampled with pready
	always_ff @(posedge clock) begin
		if (state_q == ACCESS && pready_i) begin
			inst_q <= prdata_i;
		end
	end

	assign paddr_o   = pc_q;
	assign psel_o    = (state_q == SETUP) || (state_q == ACCESS);
	assign penable_o = (state_q == ACCESS);

	assign fs_to_ds_valid_o    = fs_valid_q;
	assign fs_to_ds_bus_o.pc   = pc_q;
	assign fs_to_ds_bus_o.inst = inst_q;

endmodule

`default_nettype wire

// File: logic/rv_bru.sv
`timescale 1ns/1ps
`default_nettype none

module rv_bru (
	input  wire rv_pkg::bru_op_e  op_i,
	input  wire rv_pkg::xlen_t    pc_i,
	input  wire rv_pkg::xlen_t    src1_i,
	input  wire rv_pkg::xlen_t    src2_i,
	input  wire rv_pkg::xlen_t    imm_i,
	output logic                  taken_o,
	output rv_pkg::xlen_t         target_o,
	output rv_pkg::xlen_t         link_o
);

	logic equal;

	assign equal = (src1_i == src2_i);

	always_comb begin
		case (op_i)
			rv_pkg::BRU_BEQ: taken_o = equal;
			rv_pkg::BRU_BNE: taken_o = !equal;
			rv_pkg::BRU_JAL: taken_o = 1'b1;
			default:         taken_o = 1'b0;
		endcase
	end

	// b- and j-immediates are both pc relative
	assign target_o = pc_i + imm_i;
	assign link_o   = pc_i + 32'd4;

endmodule

`default_nettype wire

// File: logic/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
	input  wire rv_pkg::alu_op_e  op_i,
	input  wire rv_pkg::xlen_t    a_i,
	input  wire rv_pkg::xlen_t    b_i,
	output rv_pkg::xlen_t         result_o
);

	logic lt_signed;

	assign lt_signed = $signed(a_i) < $signed(b_i);

	always_comb begin
		case (op_i)
			rv_pkg::ALU_ADD:    result_o = a_i + b_i;
			// wraps modulo 2^32
			rv_pkg::ALU_SUB:    result_o = a_i - b_i;
			rv_pkg::ALU_SLT:    result_o = {31'b0, lt_signed};
			rv_pkg::ALU_XOR:    result_o = a_i ^ b_i;
			rv_pkg::ALU_OR:     result_o = a_i | b_i;
			rv_pkg::ALU_AND:    result_o = a_i & b_i;
			// lui passes the u-immediate through
			rv_pkg::ALU_PASS_B: result_o = b_i;
			default:            result_o = a_i + b_i;
		endcase
	end

endmodule

`default_nettype wire

// File: logic/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
	input  wire                    clock,
	input  wire                    arst_n_i,
	input  wire rv_pkg::reg_idx_t  raddr1_i,
	input  wire rv_pkg::reg_idx_t  raddr2_i,
	output rv_pkg::xlen_t          rdata1_o,
	output rv_pkg::xlen_t          rdata2_o,
	input  wire                    wen_i,
	input  wire rv_pkg::reg_idx_t  waddr_i,
	input  wire rv_pkg::xlen_t     wdata_i
);

	// x0 has no storage
	rv_pkg::xlen_t regs_q [31:1];

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 1; i < 32; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wen_i && waddr_i != '0) begin
			regs_q[waddr_i] <= wdata_i;
		end
	end

	assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
	assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

`default_nettype wire

// File: logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

	typedef logic [31:0] xlen_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0]  reg_idx_t;

	// base opcodes of the supported instructions
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_XOR,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {
		BRU_NONE,
		BRU_BEQ,
		BRU_BNE,
		BRU_JAL
	} bru_op_e;

	typedef struct packed {
		xlen_t pc;
		inst_t inst;
	} fs_to_ds_bus_t;

	typedef struct packed {
		xlen_t    pc;
		xlen_t    src1;
		xlen_t    src2;
		xlen_t    imm;
		logic     use_imm;
		alu_op_e  alu_op;
		bru_op_e  bru_op;
		reg_idx_t rd;
		logic     wen;
	} ds_to_es_bus_t;

	typedef struct packed {
		xlen_t pc;
		logic  valid;
	} redirect_t;

endpackage

`default_nettype wire
